// ==== rtl/rv32Pkg.sv ====
package rv32Pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // major opcodes.
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_L      = 7'b0000011,
        OP_S      = 7'b0100011,
        OP_B      = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    // ********************
    // alu operations
    // ********************
    // plain ops keep funct3 in the low bits.
    // branch conditions carry bit 3 set and funct3 below it.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_BEQ  = 4'b1000,
        ALU_BNE  = 4'b1001,
        ALU_SUB  = 4'b1010,
        ALU_SRA  = 4'b1011,
        ALU_BLT  = 4'b1100,
        ALU_BGE  = 4'b1101,
        ALU_BLTU = 4'b1110,
        ALU_BGEU = 4'b1111
    } aluOp_t;

    // write-back sources.
    typedef enum logic [2:0] {
        WB_ALU   = 3'd0,
        WB_MEM   = 3'd1,
        WB_IMM   = 3'd2,
        WB_PCIMM = 3'd3,
        WB_PC4   = 3'd4
    } wbSel_t;

    localparam word_t DEFAULT_RESET_PC = 32'h0000_0000;
    // addi x0, x0, 0.
    localparam word_t NOP_INSTR        = 32'h0000_0013;

endpackage

// ==== rtl/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  rv32Pkg::aluOp_t aluOp,
    input  rv32Pkg::word_t  a,
    input  rv32Pkg::word_t  b,
    output rv32Pkg::word_t  result,
    output logic            btaken
);
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluOp)
            rv32Pkg::ALU_ADD:  result = a + b;
            rv32Pkg::ALU_SUB:  result = a - b;
            rv32Pkg::ALU_SLL:  result = a << shamt;
            rv32Pkg::ALU_SRL:  result = a >> shamt;
            rv32Pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            rv32Pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            rv32Pkg::ALU_SLTU: result = {31'b0, a < b};
            rv32Pkg::ALU_XOR:  result = a ^ b;
            rv32Pkg::ALU_OR:   result = a | b;
            rv32Pkg::ALU_AND:  result = a & b;
            default:           result = a - b;
        endcase
    end

    // branch compare.
    always_comb begin
        case (aluOp)
            rv32Pkg::ALU_BEQ:  btaken = (a == b);
            rv32Pkg::ALU_BNE:  btaken = (a != b);
            rv32Pkg::ALU_BLT:  btaken = ($signed(a) < $signed(b));
            rv32Pkg::ALU_BGE:  btaken = ($signed(a) >= $signed(b));
            rv32Pkg::ALU_BLTU: btaken = (a < b);
            rv32Pkg::ALU_BGEU: btaken = (a >= b);
            default:           btaken = 1'b0;
        endcase
    end

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/10ps

module registerFile (
    input  logic              clk,
    input  logic              we,
    input  rv32Pkg::regAddr_t rAddr1,
    input  rv32Pkg::regAddr_t rAddr2,
    input  rv32Pkg::regAddr_t wAddr,
    input  rv32Pkg::word_t    wData,
    output rv32Pkg::word_t    rData1,
    output rv32Pkg::word_t    rData2
);
    rv32Pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[wAddr] <= wData;
        end
    end

    // x0 reads zero whatever was written.
    assign rData1 = (rAddr1 != '0) ? regs[rAddr1] : '0;
    assign rData2 = (rAddr2 != '0) ? regs[rAddr2] : '0;

endmodule

// ==== rtl/immExtend.sv ====
`timescale 1ns/10ps

module immExtend (
    input  rv32Pkg::word_t instr,
    output rv32Pkg::word_t immExt
);
    rv32Pkg::opcode_t opcode;
    logic [2:0]       funct3;

    assign opcode = rv32Pkg::opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];

    always_comb begin
        case (opcode)
            rv32Pkg::OP_I: begin
                // shifts take the 5-bit amount only.
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    immExt = {27'b0, instr[24:20]};
                end else begin
                    immExt = {{20{instr[31]}}, instr[31:20]};
                end
            end
            rv32Pkg::OP_L, rv32Pkg::OP_JALR:
                immExt = {{20{instr[31]}}, instr[31:20]};
            rv32Pkg::OP_S:
                immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv32Pkg::OP_B:
                immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            rv32Pkg::OP_LUI, rv32Pkg::OP_AUIPC:
                immExt = {instr[31:12], 12'b0};
            rv32Pkg::OP_JAL:
                immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                immExt = '0;
        endcase
    end

endmodule

// ==== rtl/instrRom.sv ====
`timescale 1ns/10ps

module instrRom #(
    parameter int romAddrBits = 8
) (
    input  rv32Pkg::word_t addr,
    output rv32Pkg::word_t data
);
    rv32Pkg::word_t rom [2**romAddrBits];

    initial begin
        $readmemh("sim/program.mem", rom);
    end

    // byte address to word index.
    assign data = rom[addr[romAddrBits+1:2]];

endmodule

// ==== rtl/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit (
    input  logic            clk,
    input  logic            reset,
    input  rv32Pkg::word_t  instr,
    output logic            regFileWe,
    output rv32Pkg::aluOp_t aluOp,
    output logic            aluSrcImm,
    output rv32Pkg::wbSel_t wbSel,
    output logic            branch,
    output logic            jal,
    output logic            jalr,
    output logic            pcEn,
    output logic            latchInstr,
    output logic            latchLoad,
    output logic            awvalid,
    input  logic            awready,
    output logic            wvalid,
    input  logic            wready,
    input  logic            bvalid,
    output logic            bready,
    output logic            arvalid,
    input  logic            arready,
    input  logic            rvalid,
    output logic            rready,
    output logic            halted
);
    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        EXECUTE,
        WRITEBACK,
        MEMWRITE,
        WRITEWAIT,
        MEMREAD,
        READWAIT,
        HALT
    } state_t;

    state_t           state;
    state_t           stateNext;
    rv32Pkg::opcode_t opcode;
    logic [2:0]       funct3;
    logic             funct7b5;
    logic             writesRd;
    logic             awDone;
    logic             wDone;
    logic             awFinish;
    logic             wFinish;

    assign opcode   = rv32Pkg::opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    function automatic rv32Pkg::aluOp_t aluFunct(input logic [2:0] f3, input logic alt);
        rv32Pkg::aluOp_t op;
        case (f3)
            3'b000:  op = alt ? rv32Pkg::ALU_SUB : rv32Pkg::ALU_ADD;
            3'b001:  op = rv32Pkg::ALU_SLL;
            3'b010:  op = rv32Pkg::ALU_SLT;
            3'b011:  op = rv32Pkg::ALU_SLTU;
            3'b100:  op = rv32Pkg::ALU_XOR;
            3'b101:  op = alt ? rv32Pkg::ALU_SRA : rv32Pkg::ALU_SRL;
            3'b110:  op = rv32Pkg::ALU_OR;
            default: op = rv32Pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // ********************
    // instruction decode
    // ********************
    always_comb begin
        aluOp     = rv32Pkg::ALU_ADD;
        aluSrcImm = 1'b0;
        wbSel     = rv32Pkg::WB_ALU;
        writesRd  = 1'b0;
        case (opcode)
            rv32Pkg::OP_R: begin
                aluOp    = aluFunct(funct3, funct7b5);
                writesRd = 1'b1;
            end
            rv32Pkg::OP_I: begin
                // only srai uses bit 30, addi never subtracts.
                aluOp     = aluFunct(funct3, funct7b5 & (funct3 == 3'b101));
                aluSrcImm = 1'b1;
                writesRd  = 1'b1;
            end
            rv32Pkg::OP_L: begin
                aluSrcImm = 1'b1;
                wbSel     = rv32Pkg::WB_MEM;
                writesRd  = 1'b1;
            end
            rv32Pkg::OP_S: begin
                aluSrcImm = 1'b1;
            end
            rv32Pkg::OP_B: begin
                aluOp = rv32Pkg::aluOp_t'({1'b1, funct3});
            end
            rv32Pkg::OP_LUI: begin
                wbSel    = rv32Pkg::WB_IMM;
                writesRd = 1'b1;
            end
            rv32Pkg::OP_AUIPC: begin
                wbSel    = rv32Pkg::WB_PCIMM;
                writesRd = 1'b1;
            end
            rv32Pkg::OP_JAL, rv32Pkg::OP_JALR: begin
                wbSel    = rv32Pkg::WB_PC4;
                writesRd = 1'b1;
            end
            default: begin
                writesRd = 1'b0;
            end
        endcase
    end

    assign branch = (opcode == rv32Pkg::OP_B);
    assign jal    = (opcode == rv32Pkg::OP_JAL);
    assign jalr   = (opcode == rv32Pkg::OP_JALR);

    // ********************
    // sequencing
    // ********************
    assign awFinish = awDone | (awvalid & awready);
    assign wFinish  = wDone | (wvalid & wready);

    always_comb begin
        stateNext = state;
        case (state)
            FETCH:     stateNext = DECODE;
            DECODE:    stateNext = EXECUTE;
            EXECUTE: begin
                case (opcode)
                    rv32Pkg::OP_B:      stateNext = FETCH;
                    rv32Pkg::OP_S:      stateNext = MEMWRITE;
                    rv32Pkg::OP_L:      stateNext = MEMREAD;
                    rv32Pkg::OP_SYSTEM: stateNext = HALT;
                    default:            stateNext = WRITEBACK;
                endcase
            end
            WRITEBACK: stateNext = FETCH;
            MEMWRITE:  if (awFinish && wFinish) stateNext = WRITEWAIT;
            WRITEWAIT: if (bvalid) stateNext = FETCH;
            MEMREAD:   if (arready) stateNext = READWAIT;
            READWAIT:  if (rvalid) stateNext = WRITEBACK;
            HALT:      stateNext = HALT;
            default:   stateNext = FETCH;
        endcase
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state  <= FETCH;
            awDone <= 1'b0;
            wDone  <= 1'b0;
        end else begin
            state <= stateNext;
            // address and data may be accepted on different cycles.
            if (state == MEMWRITE && stateNext == MEMWRITE) begin
                awDone <= awFinish;
                wDone  <= wFinish;
            end else begin
                awDone <= 1'b0;
                wDone  <= 1'b0;
            end
        end
    end

    assign latchInstr = (state == FETCH);
    assign latchLoad  = (state == READWAIT) & rvalid;
    assign regFileWe  = (state == WRITEBACK) & writesRd;
    assign pcEn       = (state == WRITEBACK) | ((state == EXECUTE) & branch)
                      | ((state == WRITEWAIT) & bvalid);
    assign awvalid    = (state == MEMWRITE) & ~awDone;
    assign wvalid     = (state == MEMWRITE) & ~wDone;
    assign bready     = (state == WRITEWAIT);
    assign arvalid    = (state == MEMREAD);
    assign rready     = (state == READWAIT);
    assign halted     = (state == HALT);

    // ********************
    // checks
    // ********************
    awvalidHeld: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid);

    // register writes only follow execute or a finished read.
    regWriteInWb: assert property (@(posedge clk) disable iff (reset)
        regFileWe |-> $past(state) == EXECUTE || $past(state) == READWAIT);

endmodule

// ==== rtl/dataPath.sv ====
`timescale 1ns/10ps

module dataPath #(
    parameter rv32Pkg::word_t resetPc = rv32Pkg::DEFAULT_RESET_PC
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            regFileWe,
    input  rv32Pkg::aluOp_t aluOp,
    input  logic            aluSrcImm,
    input  rv32Pkg::wbSel_t wbSel,
    input  logic            branch,
    input  logic            jal,
    input  logic            jalr,
    input  logic            pcEn,
    input  logic            latchInstr,
    input  logic            latchLoad,
    output rv32Pkg::word_t  pc,
    input  rv32Pkg::word_t  instrWord,
    output rv32Pkg::word_t  instr,
    output rv32Pkg::word_t  awaddr,
    output rv32Pkg::word_t  wdata,
    output rv32Pkg::word_t  araddr,
    input  rv32Pkg::word_t  rdata
);
    rv32Pkg::word_t rData1;
    rv32Pkg::word_t rData2;
    rv32Pkg::word_t immValue;
    rv32Pkg::word_t aluB;
    rv32Pkg::word_t aluResult;
    rv32Pkg::word_t wbData;
    rv32Pkg::word_t pcPlus4;
    rv32Pkg::word_t pcImmBase;
    rv32Pkg::word_t pcImm;
    rv32Pkg::word_t pcTarget;
    rv32Pkg::word_t pcNext;
    rv32Pkg::word_t pcLoad;
    rv32Pkg::word_t decRs1;
    rv32Pkg::word_t decRs2;
    rv32Pkg::word_t decImm;
    rv32Pkg::word_t exeAluResult;
    rv32Pkg::word_t exeRs2;
    rv32Pkg::word_t exePcNext;
    rv32Pkg::word_t loadData;
    logic           btaken;
    logic           takeTarget;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            instr <= rv32Pkg::NOP_INSTR;
        end else if (latchInstr) begin
            instr <= instrWord;
        end
    end

    registerFile regs (
        .clk   (clk),
        .we    (regFileWe),
        .rAddr1(instr[19:15]),
        .rAddr2(instr[24:20]),
        .wAddr (instr[11:7]),
        .wData (wbData),
        .rData1(rData1),
        .rData2(rData2)
    );

    immExtend immGen (
        .instr (instr),
        .immExt(immValue)
    );

    // ********************
    // stage registers
    // ********************
    // operands are stable from decode until the instruction retires.
    always_ff @(posedge clk) begin
        decRs1       <= rData1;
        decRs2       <= rData2;
        decImm       <= immValue;
        exeAluResult <= aluResult;
        exeRs2       <= decRs2;
        exePcNext    <= pcNext;
    end

    always_ff @(posedge clk) begin
        if (latchLoad) begin
            loadData <= rdata;
        end
    end

    assign aluB = aluSrcImm ? decImm : decRs2;

    alu aluUnit (
        .aluOp (aluOp),
        .a     (decRs1),
        .b     (aluB),
        .result(aluResult),
        .btaken(btaken)
    );

    always_comb begin
        case (wbSel)
            rv32Pkg::WB_MEM:   wbData = loadData;
            rv32Pkg::WB_IMM:   wbData = decImm;
            rv32Pkg::WB_PCIMM: wbData = pcImm;
            rv32Pkg::WB_PC4:   wbData = pcPlus4;
            default:           wbData = aluResult;
        endcase
    end

    // ********************
    // next pc
    // ********************
    assign pcPlus4    = pc + 32'd4;
    assign pcImmBase  = jalr ? decRs1 : pc;
    assign pcImm      = pcImmBase + decImm;
    assign pcTarget   = jalr ? {pcImm[31:1], 1'b0} : pcImm;
    assign takeTarget = jal | jalr | (branch & btaken);
    assign pcNext     = takeTarget ? pcTarget : pcPlus4;
    // branches retire in execute before the stage register is valid.
    assign pcLoad     = branch ? pcNext : exePcNext;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pc <= resetPc;
        end else if (pcEn) begin
            pc <= pcLoad;
        end
    end

    assign awaddr = exeAluResult;
    assign araddr = exeAluResult;
    assign wdata  = exeRs2;

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== rtl/rv32Core.sv ====
`timescale 1ns/10ps

module rv32Core #(
    parameter rv32Pkg::word_t resetPc     = rv32Pkg::DEFAULT_RESET_PC,
    parameter int             romAddrBits = 8
) (
    input  logic           clk,
    input  logic           reset,
    output rv32Pkg::word_t awaddr,
    output logic           awvalid,
    input  logic           awready,
    output rv32Pkg::word_t wdata,
    output logic           wvalid,
    input  logic           wready,
    input  logic [1:0]     bresp,
    input  logic           bvalid,
    output logic           bready,
    output rv32Pkg::word_t araddr,
    output logic           arvalid,
    input  logic           arready,
    input  rv32Pkg::word_t rdata,
    input  logic [1:0]     rresp,
    input  logic           rvalid,
    output logic           rready,
    output logic           halted
);
    logic            regFileWe;
    rv32Pkg::aluOp_t aluOp;
    logic            aluSrcImm;
    rv32Pkg::wbSel_t wbSel;
    logic            branch;
    logic            jal;
    logic            jalr;
    logic            pcEn;
    logic            latchInstr;
    logic            latchLoad;
    rv32Pkg::word_t  pc;
    rv32Pkg::word_t  instrWord;
    rv32Pkg::word_t  instr;

    controlUnit ctrl (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .regFileWe (regFileWe),
        .aluOp     (aluOp),
        .aluSrcImm (aluSrcImm),
        .wbSel     (wbSel),
        .branch    (branch),
        .jal       (jal),
        .jalr      (jalr),
        .pcEn      (pcEn),
        .latchInstr(latchInstr),
        .latchLoad (latchLoad),
        .awvalid   (awvalid),
        .awready   (awready),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .arvalid   (arvalid),
        .arready   (arready),
        .rvalid    (rvalid),
        .rready    (rready),
        .halted    (halted)
    );

    dataPath #(
        .resetPc(resetPc)
    ) path (
        .clk       (clk),
        .reset     (reset),
        .regFileWe (regFileWe),
        .aluOp     (aluOp),
        .aluSrcImm (aluSrcImm),
        .wbSel     (wbSel),
        .branch    (branch),
        .jal       (jal),
        .jalr      (jalr),
        .pcEn      (pcEn),
        .latchInstr(latchInstr),
        .latchLoad (latchLoad),
        .pc        (pc),
        .instrWord (instrWord),
        .instr     (instr),
        .awaddr    (awaddr),
        .wdata     (wdata),
        .araddr    (araddr),
        .rdata     (rdata)
    );

    instrRom #(
        .romAddrBits(romAddrBits)
    ) rom (
        .addr(pc),
        .data(instrWord)
    );

endmodule

// ==== sim/tbRv32Core.sv ====
`timescale 1ns/10ps

module tbRv32Core;
    localparam int SEED       = 41;
    localparam int PERIOD     = 4;
    localparam int NUM_STORES = 15;
    localparam rv32Pkg::word_t LOAD_ADDR  = 32'h0000_0200;
    localparam rv32Pkg::word_t LOAD_VALUE = 32'h1234_5670;

    // expected stores, in program order.
    localparam rv32Pkg::word_t EXP_ADDR [NUM_STORES] = '{
        32'h100, 32'h104, 32'h108, 32'h10C, 32'h110, 32'h114, 32'h118, 32'h11C,
        32'h120, 32'h124, 32'h128, 32'h12C, 32'h130, 32'h134, 32'h138
    };
    localparam rv32Pkg::word_t EXP_DATA [NUM_STORES] = '{
        32'd2, 32'd8, 32'd1, 32'd0, 32'h0000_00F5, 32'hFFFF_FFFE, 32'h07FF_FFFF, 32'd0,
        32'h1234_5000, 32'h0000_1050, LOAD_VALUE + 32'h11, 32'd5, 32'hFFFF_FFFD,
        32'h0000_0084, 32'h0000_0094
    };

    logic           clk = 1'b0;
    logic           reset;
    rv32Pkg::word_t awaddr;
    logic           awvalid;
    logic           awready;
    rv32Pkg::word_t wdata;
    logic           wvalid;
    logic           wready;
    logic [1:0]     bresp;
    logic           bvalid;
    logic           bready;
    rv32Pkg::word_t araddr;
    logic           arvalid;
    logic           arready;
    rv32Pkg::word_t rdata;
    logic [1:0]     rresp;
    logic           rvalid;
    logic           rready;
    logic           halted;

    rv32Pkg::word_t mem [rv32Pkg::word_t];
    rv32Pkg::word_t awLatch;
    rv32Pkg::word_t wLatch;
    rv32Pkg::word_t arLatch;
    rv32Pkg::word_t addrQ;
    rv32Pkg::word_t dataQ;
    rv32Pkg::word_t readAddr;
    logic           awHit = 1'b0;
    logic           wHit = 1'b0;
    logic           bHit = 1'b0;
    logic           arHit = 1'b0;
    logic           rHit = 1'b0;
    logic           fetched = 1'b0;
    logic           gotAw = 1'b0;
    logic           gotW = 1'b0;
    logic           bPending = 1'b0;
    logic           rPending = 1'b0;
    int             awWait;
    int             wWait;
    int             bWait;
    int             arWait;
    int             rWait;
    int             storeCount = 0;

    rv32Core i_dut (
        .clk    (clk),
        .reset  (reset),
        .awaddr (awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata  (wdata),
        .wvalid (wvalid),
        .wready (wready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready),
        .araddr (araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready),
        .halted (halted)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic reportMismatch(input string name, input rv32Pkg::word_t expected,
                                  input rv32Pkg::word_t actual);
        $display("FAIL at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportProblem(input string what);
        $display("Error at %0d ns: %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkStore(input rv32Pkg::word_t addr, input rv32Pkg::word_t data);
        if (storeCount >= NUM_STORES) begin
            reportProblem("a store arrived that the program should have skipped");
        end
        assert (addr == EXP_ADDR[storeCount])
            else reportMismatch("awaddr", EXP_ADDR[storeCount], addr);
        assert (data == EXP_DATA[storeCount])
            else reportMismatch("wdata", EXP_DATA[storeCount], data);
        mem[addr] = data;
        storeCount++;
    endtask

    // ********************
    // AXI4-Lite slave
    // ********************
    // handshakes seen on the rising edge, handled on the falling one.
    always @(posedge clk) begin
        awHit   <= awvalid && awready;
        awLatch <= awaddr;
        wHit    <= wvalid && wready;
        wLatch  <= wdata;
        bHit    <= bvalid && bready;
        arHit   <= arvalid && arready;
        arLatch <= araddr;
        rHit    <= rvalid && rready;
        if (i_dut.latchInstr) begin
            fetched <= 1'b1;
        end
    end

    always @(negedge clk) begin
        if (awHit) begin
            gotAw  = 1'b1;
            addrQ  = awLatch;
            awWait = $urandom % 4;
        end
        if (wHit) begin
            gotW  = 1'b1;
            dataQ = wLatch;
            wWait = $urandom % 4;
        end
        if (gotAw && gotW) begin
            checkStore(addrQ, dataQ);
            gotAw    = 1'b0;
            gotW     = 1'b0;
            bPending = 1'b1;
            bWait    = $urandom % 4;
        end
        if (bHit) begin
            bPending = 1'b0;
        end
        if (arHit) begin
            rPending = 1'b1;
            readAddr = arLatch;
            arWait   = $urandom % 4;
            rWait    = $urandom % 4;
        end
        if (rHit) begin
            rPending = 1'b0;
        end

        awready = 1'b0;
        if (awvalid) begin
            if (awWait == 0) awready = 1'b1;
            else awWait--;
        end
        wready = 1'b0;
        if (wvalid) begin
            if (wWait == 0) wready = 1'b1;
            else wWait--;
        end
        arready = 1'b0;
        if (arvalid) begin
            if (arWait == 0) arready = 1'b1;
            else arWait--;
        end
        bvalid = 1'b0;
        if (bPending) begin
            if (bWait == 0) bvalid = 1'b1;
            else bWait--;
        end
        rvalid = 1'b0;
        if (rPending) begin
            // unwritten words read back a pattern of their address.
            rdata = mem.exists(readAddr) ? mem[readAddr] : (readAddr ^ 32'hA5A5_A5A5);
            if (rWait == 0) rvalid = 1'b1;
            else rWait--;
        end
    end

    // ********************
    // protocol checks
    // ********************
    resetQuiet: assert property (@(posedge clk) reset || $fell(reset) |->
        !awvalid && !wvalid && !arvalid && !bready && !rready && !halted
        && !awready && !wready && !arready && !bvalid && !rvalid)
        else reportProblem("an AXI valid, ready or halted was high around reset");

    writeAfterFetch: assert property (@(posedge clk) disable iff (reset)
        awvalid |-> fetched)
        else reportProblem("write address issued before any instruction fetch");

    awHeld: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else reportProblem("awvalid dropped or awaddr changed before awready");

    wHeld: assert property (@(posedge clk) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else reportProblem("wvalid dropped or wdata changed before wready");

    arHeld: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else reportProblem("arvalid dropped or araddr changed before arready");

    oneInFlight: assert property (@(posedge clk) disable iff (reset)
        awvalid || wvalid || arvalid |-> !bPending && !rPending)
        else reportProblem("new request started before the previous response");

    storesAtHalt: assert property (@(posedge clk) disable iff (reset)
        $rose(halted) |-> storeCount == NUM_STORES)
        else reportMismatch("store count", NUM_STORES, storeCount);

    // watchdog, 400 instructions at 20 cycles worst case.
    initial begin
        #(400 * 20 * PERIOD);
        reportProblem("timeout, the core never halted");
    end

    initial begin
        reset   = 1'b1;
        awready = 1'b0;
        wready  = 1'b0;
        bresp   = 2'b00;
        bvalid  = 1'b0;
        arready = 1'b0;
        rdata   = '0;
        rresp   = 2'b00;
        rvalid  = 1'b0;
        // the first draw seeds the generator.
        awWait  = $urandom(SEED) % 4;
        wWait   = $urandom % 4;
        arWait  = $urandom % 4;
        bWait   = 0;
        rWait   = 0;
        mem[LOAD_ADDR]   = LOAD_VALUE;
        mem[32'h0000_0204] = 32'hDEAD_BEEF;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        wait (halted);
        // the halt check samples halted on the next rising edge.
        @(posedge clk);
        @(negedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== rv32Core.f ====
rtl/rv32Pkg.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/immExtend.sv
rtl/instrRom.sv
rtl/controlUnit.sv
rtl/dataPath.sv
rtl/rv32Core.sv
sim/tbRv32Core.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the testbench with Verilator, then checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbRv32Core \
    -f rv32Core.f -o tbRv32Core || { echo "build failed"; exit 1; }

./obj_dir/tbRv32Core > sim.log 2>&1
cat sim.log

grep -q "Finished with no errors" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

// ==== sim/program.mem ====
// one 32-bit RV32I instruction per line, in hex, from address 0 upward.
00500093
FFD00113
002081B3
10302023
40208233
10402223
001122B3
00113333
10502423
10602623
0F00C393
10702823
40115413
10802A23
001154B3
10902C23
00708013
10002E23
12345537
12A02023
00001597
12B02223
20002603
01160613
12C02423
00208463
12102623
00114463
1E102E23
12202823
00117463
1E102E23
00C006EF
1E102E23
1E102E23
12D02A23
0A000767
1E102E23
1E102E23
1E102E23
12E02C23
00000073
